//--- ve_config.svh
`ifndef VE_CONFIG_SVH
`define VE_CONFIG_SVH

// datapath widths
`define VE_PC_WIDTH 8          // program counter, one instruction word per pc
`define VE_CC_ID_BITS 2        // character index, lane count is 2**this
`define VE_CHAR_WIDTH 8
`define VE_INSTR_WIDTH 16      // opcode in the top two bits, operand in the low byte

// memory side
`define VE_MEM_ADDR_WIDTH 8    // word address, equal to the pc width

// per lane storage
`define VE_CACHE_INDEX_BITS 3  // 8 one-word lines
`define VE_FIFO_DEPTH_LOG2 3   // 8 pending threads per lane

`endif

//--- ve_pkg.sv
`include "ve_config.svh"

package ve_pkg;

  // plain vectors for the widths that mean something
  typedef logic [`VE_PC_WIDTH-1:0] pc_t;
  typedef logic [`VE_CC_ID_BITS-1:0] cc_id_t;        // also used as lane index
  typedef logic [`VE_CHAR_WIDTH-1:0] char_t;
  typedef logic [`VE_INSTR_WIDTH-1:0] instr_t;
  typedef logic [`VE_MEM_ADDR_WIDTH-1:0] mem_addr_t; // pc is the word address

  // opcode sits in instr[15:14]
  typedef enum logic [1:0] {
    OP_MATCH  = 2'd0,  // operand is the char to compare
    OP_JMP    = 2'd1,  // operand is the target pc
    OP_SPLIT  = 2'd2,  // fork to pc+1 and target
    OP_ACCEPT = 2'd3
  } opcode_e;

  // one thread, pc in the upper bits and cc_id in the lower ones
  typedef struct packed {
    pc_t    pc;
    cc_id_t cc_id;
  } thread_t;

  typedef enum logic [1:0] {CPU_IDLE, CPU_FETCH, CPU_EXEC, CPU_EMIT2} cpu_state_e;

  typedef enum logic {CACHE_IDLE, CACHE_MISS} cache_state_e;

endpackage

//--- ve_if.sv
`timescale 1ns/1ps

// thread stream between arbiters, fifos and cpus
interface pc_stream_if;
  logic            valid;
  logic            ready;
  ve_pkg::thread_t thread;  // held stable while valid && !ready

  modport src (
    output valid,
    output thread,
    input  ready
  );

  modport dst (
    input  valid,
    input  thread,
    output ready
  );
endinterface

// instruction fetch, cpu to its own cache
interface icache_if;
  logic              valid;
  logic              ready;  // one cycle pulse, comes with data
  ve_pkg::mem_addr_t addr;
  ve_pkg::instr_t    data;

  modport cpu (
    output valid,
    output addr,
    input  ready,
    input  data
  );

  modport cache (
    input  valid,
    input  addr,
    output ready,
    output data
  );
endinterface

//--- pc_fifo.sv
`timescale 1ns/1ps
`include "ve_config.svh"

module pc_fifo (
  input  logic     clk,
  input  logic     rst_n,
  pc_stream_if.dst wr,
  pc_stream_if.src rd,
  output logic     full
);
  localparam int DEPTH = 1 << `VE_FIFO_DEPTH_LOG2;

  ve_pkg::thread_t                 mem [DEPTH];
  logic [`VE_FIFO_DEPTH_LOG2-1:0]  wr_ptr;
  logic [`VE_FIFO_DEPTH_LOG2-1:0]  rd_ptr;
  logic [`VE_FIFO_DEPTH_LOG2:0]    count;       // one extra bit to hold DEPTH
  logic [`VE_FIFO_DEPTH_LOG2:0]    count_next;
  logic                            empty;
  logic                            do_wr;
  logic                            do_rd;

  assign do_wr = wr.valid && !full;
  assign do_rd = rd.ready && !empty;

  assign wr.ready  = !full;
  assign rd.valid  = !empty;
  assign rd.thread = mem[rd_ptr];  // head, visible the cycle after its write

  always_comb begin
    case ({do_wr, do_rd})
      2'b10:   count_next = count + 1'b1;
      2'b01:   count_next = count - 1'b1;
      default: count_next = count;  // both or neither
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      full   <= 1'b0;
      empty  <= 1'b1;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + 1'b1;  // pointers wrap on their own
      if (do_rd) rd_ptr <= rd_ptr + 1'b1;
      count <= count_next;
      full  <= (count_next == DEPTH[`VE_FIFO_DEPTH_LOG2:0]);
      empty <= (count_next == '0);
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (do_wr) mem[wr_ptr] <= wr.thread;
  end

endmodule

//--- pc_arbiter_2rr.sv
`timescale 1ns/1ps

module pc_arbiter_2rr (
  input  logic     clk,
  input  logic     rst_n,
  pc_stream_if.dst in0,  // same lane, from the own cpu
  pc_stream_if.dst in1,  // upstream lane or the input port
  pc_stream_if.src out
);
  logic last_grant;  // 1 when in1 won the last transfer
  logic pick1;

  // when both wait, the one that lost last time goes first
  always_comb begin
    if (in0.valid && in1.valid) begin
      pick1 = !last_grant;
    end else begin
      pick1 = in1.valid;
    end
  end

  assign out.valid  = in0.valid || in1.valid;
  assign out.thread = pick1 ? in1.thread : in0.thread;
  assign in0.ready  = out.ready && !pick1;
  assign in1.ready  = out.ready && pick1;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_grant <= 1'b0;
    end else if (out.valid && out.ready) begin
      last_grant <= pick1;  // only moves on a real transfer
    end
  end

endmodule

//--- mem_arbiter_rr.sv
`timescale 1ns/1ps
`include "ve_config.svh"

module mem_arbiter_rr (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic [(1 << `VE_CC_ID_BITS)-1:0]     req_valid,
  input  ve_pkg::mem_addr_t                    req_addr [1 << `VE_CC_ID_BITS],
  output logic [(1 << `VE_CC_ID_BITS)-1:0]     req_ready,
  output logic                                 memory_valid,
  output ve_pkg::mem_addr_t                    memory_addr,
  input  logic                                 memory_ready
);
  localparam int N = 1 << `VE_CC_ID_BITS;

  ve_pkg::cc_id_t ptr;      // lane with top priority
  ve_pkg::cc_id_t winner;
  ve_pkg::cc_id_t granted;  // lane whose address sits on the port
  ve_pkg::cc_id_t idx;
  logic           found;

  // scan starting at ptr, index wraps since N is a power of two
  always_comb begin
    found  = 1'b0;
    winner = ptr;
    for (int k = 0; k < N; k++) begin
      idx = ptr + ve_pkg::cc_id_t'(k);
      if (!found && req_valid[idx]) begin
        found  = 1'b1;
        winner = idx;
      end
    end
  end

  // grant only while the port is free
  always_comb begin
    req_ready = '0;
    if (!memory_valid && found) req_ready[winner] = 1'b1;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      memory_valid <= 1'b0;
      ptr          <= '0;
      granted      <= '0;
    end else if (memory_valid) begin
      if (memory_ready) begin
        memory_valid <= 1'b0;
        ptr          <= granted + 1'b1;  // next round starts past the winner
      end
    end else if (found) begin
      memory_valid <= 1'b1;
      granted      <= winner;
    end
  end

  always_ff @(posedge clk) begin
    if (!memory_valid && found) memory_addr <= req_addr[winner];  // held until accepted
  end

endmodule

//--- icache_dm.sv
`timescale 1ns/1ps
`include "ve_config.svh"

module icache_dm (
  input  logic              clk,
  input  logic              rst_n,
  icache_if.cache           cpu,
  output logic              miss_valid,
  output ve_pkg::mem_addr_t miss_addr,
  input  logic              miss_ready,
  input  logic              fill_valid,
  input  ve_pkg::mem_addr_t fill_addr,
  input  ve_pkg::instr_t    fill_data
);
  localparam int IDX_W = `VE_CACHE_INDEX_BITS;
  localparam int TAG_W = `VE_MEM_ADDR_WIDTH - IDX_W;
  localparam int LINES = 1 << IDX_W;

  ve_pkg::instr_t       data_mem [LINES];
  logic [TAG_W-1:0]     tag_mem  [LINES];
  logic [LINES-1:0]     line_valid;
  ve_pkg::cache_state_e state;
  logic                 issued;     // request already taken by the memory arbiter
  logic [IDX_W-1:0]     req_idx;
  logic [TAG_W-1:0]     req_tag;
  logic [IDX_W-1:0]     fill_idx;
  logic                 hit;
  logic                 fill_hit;   // broadcast carries the word being asked for

  assign req_idx  = cpu.addr[IDX_W-1:0];
  assign req_tag  = cpu.addr[`VE_MEM_ADDR_WIDTH-1:IDX_W];
  assign fill_idx = fill_addr[IDX_W-1:0];

  assign hit      = line_valid[req_idx] && (tag_mem[req_idx] == req_tag);
  assign fill_hit = fill_valid && (fill_addr == cpu.addr);

  // answer in the same cycle on a hit, or straight from a matching broadcast
  assign cpu.ready = cpu.valid && (hit || fill_hit);
  assign cpu.data  = fill_hit ? fill_data : data_mem[req_idx];

  // cpu holds addr stable while waiting, so it doubles as the miss address
  assign miss_valid = (state == ve_pkg::CACHE_MISS) && !issued;
  assign miss_addr  = cpu.addr;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= ve_pkg::CACHE_IDLE;
      issued     <= 1'b0;
      line_valid <= '0;
    end else begin
      if (fill_valid) line_valid[fill_idx] <= 1'b1;  // any broadcast fills its line
      case (state)
        ve_pkg::CACHE_IDLE: begin
          if (cpu.valid && !cpu.ready) state <= ve_pkg::CACHE_MISS;
        end
        ve_pkg::CACHE_MISS: begin
          if (fill_hit) begin
            state  <= ve_pkg::CACHE_IDLE;
            issued <= 1'b0;
          end else if (miss_valid && miss_ready) begin
            issued <= 1'b1;  // ask once, then only wait
          end
        end
        default: state <= ve_pkg::CACHE_IDLE;
      endcase
    end
  end

  // line storage
  always_ff @(posedge clk) begin
    if (fill_valid) begin
      data_mem[fill_idx] <= fill_data;
      tag_mem[fill_idx]  <= fill_addr[`VE_MEM_ADDR_WIDTH-1:IDX_W];
    end
  end

endmodule

//--- regex_cpu.sv
`timescale 1ns/1ps
`include "ve_config.svh"

module regex_cpu (
  input  logic          clk,
  input  logic          rst_n,
  input  ve_pkg::char_t lane_char,
  input  logic          lane_end,   // string ended before this position
  pc_stream_if.dst      in,
  pc_stream_if.src      out,
  icache_if.cpu         fetch,
  output logic          accept_hit,
  output logic          busy
);
  ve_pkg::cpu_state_e state;
  ve_pkg::pc_t        pc_q;
  ve_pkg::cc_id_t     cc_q;      // lane index comes with the thread
  ve_pkg::instr_t     instr_q;
  ve_pkg::opcode_e    op;
  ve_pkg::char_t      op_char;
  ve_pkg::pc_t        op_target;
  ve_pkg::pc_t        pc_next;
  logic               char_hit;

  // decode
  assign op        = ve_pkg::opcode_e'(instr_q[`VE_INSTR_WIDTH-1 -: 2]);
  assign op_char   = instr_q[`VE_CHAR_WIDTH-1:0];
  assign op_target = instr_q[`VE_PC_WIDTH-1:0];
  assign pc_next   = pc_q + 1'b1;
  assign char_hit  = (lane_char == op_char) && !lane_end;  // nothing matches past the end

  assign in.ready    = (state == ve_pkg::CPU_IDLE);
  assign busy        = (state != ve_pkg::CPU_IDLE);
  assign fetch.valid = (state == ve_pkg::CPU_FETCH);
  assign fetch.addr  = pc_q;
  assign accept_hit  = (state == ve_pkg::CPU_EXEC) && (op == ve_pkg::OP_ACCEPT) && lane_end;

  // result thread, stays put until the consumer takes it
  always_comb begin
    out.valid        = 1'b0;
    out.thread.pc    = pc_next;
    out.thread.cc_id = cc_q;
    case (state)
      ve_pkg::CPU_EXEC: begin
        case (op)
          ve_pkg::OP_MATCH: begin
            out.valid        = char_hit;
            out.thread.cc_id = cc_q + 1'b1;  // moves on to the next lane
          end
          ve_pkg::OP_JMP: begin
            out.valid     = 1'b1;
            out.thread.pc = op_target;
          end
          ve_pkg::OP_SPLIT: out.valid = 1'b1;  // pc+1 first
          default: out.valid = 1'b0;          // accept emits no thread
        endcase
      end
      ve_pkg::CPU_EMIT2: begin
        out.valid     = 1'b1;  // second half of a split
        out.thread.pc = op_target;
      end
      default: out.valid = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ve_pkg::CPU_IDLE;
    end else begin
      case (state)
        ve_pkg::CPU_IDLE: begin
          if (in.valid && in.ready) state <= ve_pkg::CPU_FETCH;
        end
        ve_pkg::CPU_FETCH: begin
          if (fetch.ready) state <= ve_pkg::CPU_EXEC;
        end
        ve_pkg::CPU_EXEC: begin
          if (op == ve_pkg::OP_SPLIT) begin
            if (out.ready) state <= ve_pkg::CPU_EMIT2;
          end else if (!out.valid || out.ready) begin
            state <= ve_pkg::CPU_IDLE;  // done, or nothing to emit
          end
        end
        ve_pkg::CPU_EMIT2: begin
          if (out.ready) state <= ve_pkg::CPU_IDLE;
        end
        default: state <= ve_pkg::CPU_IDLE;
      endcase
    end
  end

  // thread and instruction registers
  always_ff @(posedge clk) begin
    if (in.valid && in.ready) begin
      pc_q <= in.thread.pc;
      cc_q <= in.thread.cc_id;
    end
    if (fetch.valid && fetch.ready) instr_q <= fetch.data;
  end

endmodule

//--- vectorial_engine.sv
`timescale 1ns/1ps
`include "ve_config.svh"

module vectorial_engine (
  input  logic                                                  clk,
  input  logic                                                  rst_n,
  input  logic                                                  new_char,
  input  logic [(1 << `VE_CC_ID_BITS)*`VE_CHAR_WIDTH-1:0]       cur_window,
  input  logic [(1 << `VE_CC_ID_BITS)-1:0]                      cur_window_enable,
  input  logic [(1 << `VE_CC_ID_BITS)-1:0]                      cur_window_end_of_s,
  input  logic                                                  input_pc_valid,
  input  logic [`VE_PC_WIDTH+`VE_CC_ID_BITS-1:0]                input_pc_and_cc_id,
  output logic                                                  input_pc_ready,
  output logic                                                  output_pc_valid,
  output logic [`VE_PC_WIDTH+`VE_CC_ID_BITS-1:0]                output_pc_and_cc_id,
  input  logic                                                  output_pc_ready,
  output logic                                                  memory_valid,
  output logic [`VE_MEM_ADDR_WIDTH-1:0]                         memory_addr,
  input  logic                                                  memory_ready,
  input  logic                                                  memory_broadcast_valid,
  input  logic [`VE_MEM_ADDR_WIDTH-1:0]                         memory_broadcast_addr,
  input  logic [`VE_INSTR_WIDTH-1:0]                            memory_data,
  output logic                                                  accepts,
  output logic                                                  running,
  output logic                                                  full,
  output logic [(1 << `VE_CC_ID_BITS)-1:0]                      elaborating_chars
);
  localparam int LANES = 1 << `VE_CC_ID_BITS;
  localparam int CW    = `VE_CHAR_WIDTH;

  pc_stream_if own_s     [LANES] ();  // cpu i back to arbiter i
  pc_stream_if next_s    [LANES] ();  // arbiter i from lane i-1, lane 0 from the input port
  pc_stream_if arb_out_s [LANES] ();
  pc_stream_if fifo_rd_s [LANES] ();
  pc_stream_if cpu_in_s  [LANES] ();  // fifo head after the window enable gate
  pc_stream_if cpu_out_s [LANES] ();
  icache_if    fetch_s   [LANES] ();

  logic [LANES-1:0]  miss_valid;
  logic [LANES-1:0]  miss_ready;
  ve_pkg::mem_addr_t miss_addr [LANES];
  logic [LANES-1:0]  fifo_full;
  logic [LANES-1:0]  fifo_has_data;
  logic [LANES-1:0]  cpu_busy;
  logic [LANES-1:0]  accept_hit;
  logic [LANES-1:0]  advance;  // cpu output left its lane

  // lane 0 upstream side is the engine input
  assign next_s[0].valid  = input_pc_valid;
  assign next_s[0].thread = ve_pkg::thread_t'(input_pc_and_cc_id);
  assign input_pc_ready   = next_s[0].ready;

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    pc_arbiter_2rr arbiter_to_fifo (
      .clk   (clk),
      .rst_n (rst_n),
      .in0   (own_s[i]),
      .in1   (next_s[i]),
      .out   (arb_out_s[i])
    );

    pc_fifo fifo_cc_id (
      .clk   (clk),
      .rst_n (rst_n),
      .wr    (arb_out_s[i]),
      .rd    (fifo_rd_s[i]),
      .full  (fifo_full[i])
    );

    // a disabled lane neither shows nor pops its head
    assign fifo_has_data[i]   = fifo_rd_s[i].valid;
    assign cpu_in_s[i].valid  = fifo_rd_s[i].valid && cur_window_enable[i];
    assign cpu_in_s[i].thread = fifo_rd_s[i].thread;
    assign fifo_rd_s[i].ready = cpu_in_s[i].ready && cur_window_enable[i];

    regex_cpu a_regex_cpu (
      .clk        (clk),
      .rst_n      (rst_n),
      .lane_char  (cur_window[i*CW +: CW]),
      .lane_end   (cur_window_end_of_s[i]),
      .in         (cpu_in_s[i]),
      .out        (cpu_out_s[i]),
      .fetch      (fetch_s[i]),
      .accept_hit (accept_hit[i]),
      .busy       (cpu_busy[i])
    );

    icache_dm cpu_cache (
      .clk        (clk),
      .rst_n      (rst_n),
      .cpu        (fetch_s[i]),
      .miss_valid (miss_valid[i]),
      .miss_addr  (miss_addr[i]),
      .miss_ready (miss_ready[i]),
      .fill_valid (memory_broadcast_valid),  // every cache sees every word
      .fill_addr  (memory_broadcast_addr),
      .fill_data  (memory_data)
    );

    // steer by cc_id, same lane loops back, anything else goes downstream
    assign advance[i]       = (cpu_out_s[i].thread.cc_id != ve_pkg::cc_id_t'(i));
    assign own_s[i].valid   = cpu_out_s[i].valid && !advance[i];
    assign own_s[i].thread  = cpu_out_s[i].thread;

    if (i < LANES - 1) begin : g_mid
      assign next_s[i+1].valid  = cpu_out_s[i].valid && advance[i];
      assign next_s[i+1].thread = cpu_out_s[i].thread;
      assign cpu_out_s[i].ready = advance[i] ? next_s[i+1].ready : own_s[i].ready;
    end else begin : g_last
      // cc_id wrapped to 0, thread continues in the next window
      assign output_pc_valid     = cpu_out_s[i].valid && advance[i];
      assign output_pc_and_cc_id = cpu_out_s[i].thread;
      assign cpu_out_s[i].ready  = advance[i] ? output_pc_ready : own_s[i].ready;
    end
  end

  mem_arbiter_rr arbiter_tree_to_memory (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid    (miss_valid),
    .req_addr     (miss_addr),
    .req_ready    (miss_ready),
    .memory_valid (memory_valid),
    .memory_addr  (memory_addr),
    .memory_ready (memory_ready)
  );

  // sticky match flag, a new window starts it over
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      accepts <= 1'b0;
    end else if (new_char) begin
      accepts <= 1'b0;
    end else if (|accept_hit) begin
      accepts <= 1'b1;
    end
  end

  // status
  assign running           = |((fifo_has_data & cur_window_enable) | cpu_busy);
  assign full              = &fifo_full;
  assign elaborating_chars = fifo_has_data | cpu_busy;

endmodule

//--- tb_vectorial_engine.sv
`timescale 1ns/1ps
`include "ve_config.svh"

module tb_vectorial_engine;
  localparam int LANES      = 1 << `VE_CC_ID_BITS;
  localparam int CW         = `VE_CHAR_WIDTH;
  localparam int TW         = `VE_PC_WIDTH + `VE_CC_ID_BITS;
  localparam int CLK_PERIOD = 20;
  localparam int N_TRIALS   = 40;
  localparam int MAX_PROG   = 16;
  localparam int MAX_VISITS = 8;   // thread visits per program, never more than a fifo holds

  // opcodes in instr[15:14]
  localparam logic [1:0] OPC_MATCH  = 2'd0;
  localparam logic [1:0] OPC_JMP    = 2'd1;
  localparam logic [1:0] OPC_SPLIT  = 2'd2;
  localparam logic [1:0] OPC_ACCEPT = 2'd3;

  logic                     clk = 1'b0;
  logic                     rst_n;
  logic                     new_char;
  logic [LANES*CW-1:0]      cur_window;
  logic [LANES-1:0]         cur_window_enable;
  logic [LANES-1:0]         cur_window_end_of_s;
  logic                     input_pc_valid;
  logic [TW-1:0]            input_pc_and_cc_id;
  logic                     input_pc_ready;
  logic                     output_pc_valid;
  logic [TW-1:0]            output_pc_and_cc_id;
  logic                     output_pc_ready;
  logic                     memory_valid;
  logic [`VE_MEM_ADDR_WIDTH-1:0] memory_addr;
  logic                     memory_ready;
  logic                     memory_broadcast_valid;
  logic [`VE_MEM_ADDR_WIDTH-1:0] memory_broadcast_addr;
  logic [`VE_INSTR_WIDTH-1:0]    memory_data;
  logic                     accepts;
  logic                     running;
  logic                     full;
  logic [LANES-1:0]         elaborating_chars;

  logic [`VE_INSTR_WIDTH-1:0] prog [256];  // program memory image
  int                         prog_len;
  logic [CW-1:0]              win_char [LANES];
  logic [LANES-1:0]           end_flag;
  bit                         exp_accept;
  int                         exp_out[$];
  int                         got_out[$];
  bit                         stall_mode;     // random back-pressure on the output port
  int                         error_count = 0;
  int                         check_count = 0;
  bit                         hold_out = 1'b0;
  bit                         hold_mem = 1'b0;
  logic [TW-1:0]              last_out;
  logic [`VE_MEM_ADDR_WIDTH-1:0] last_mem_addr;

  always #(CLK_PERIOD/2) clk = ~clk;

  vectorial_engine vectorial_engine_inst (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .new_char               (new_char),
    .cur_window             (cur_window),
    .cur_window_enable      (cur_window_enable),
    .cur_window_end_of_s    (cur_window_end_of_s),
    .input_pc_valid         (input_pc_valid),
    .input_pc_and_cc_id     (input_pc_and_cc_id),
    .input_pc_ready         (input_pc_ready),
    .output_pc_valid        (output_pc_valid),
    .output_pc_and_cc_id    (output_pc_and_cc_id),
    .output_pc_ready        (output_pc_ready),
    .memory_valid           (memory_valid),
    .memory_addr            (memory_addr),
    .memory_ready           (memory_ready),
    .memory_broadcast_valid (memory_broadcast_valid),
    .memory_broadcast_addr  (memory_broadcast_addr),
    .memory_data            (memory_data),
    .accepts                (accepts),
    .running                (running),
    .full                   (full),
    .elaborating_chars      (elaborating_chars)
  );

  task automatic compare_value(input string name, input int got, input int expected);
    check_count++;
    assert (got == expected) else begin
      error_count++;
      $display("[ERROR] %s: got %h expected %h", name, got, expected);
    end
  endtask

  // random forward-only program, last word is accept so no pc runs off the end
  task automatic make_program();
    int         visits [256];
    int         total;
    int         pick;
    int         tgt;
    logic [1:0] op;
    logic [7:0] arg;
    total = MAX_VISITS + 1;
    while (total > MAX_VISITS) begin
      prog_len = $urandom_range(2, MAX_PROG);
      for (int a = 0; a < 256; a++) prog[a] = {OPC_ACCEPT, 6'h2a, 8'(a)};  // unused words
      for (int pc = 0; pc < prog_len - 1; pc++) begin
        pick = $urandom_range(0, 99);
        tgt  = $urandom_range(pc + 1, prog_len - 1);
        if (pick < 50) begin
          op  = OPC_MATCH;
          arg = 8'h61 + 8'($urandom_range(0, 2));  // 'a' to 'c'
        end else if (pick < 65) begin
          op  = OPC_JMP;
          arg = 8'(tgt);
        end else if (pick < 85) begin
          op  = OPC_SPLIT;
          arg = 8'(tgt);
        end else begin
          op  = OPC_ACCEPT;
          arg = 8'h00;
        end
        prog[pc] = {op, 6'h00, arg};
      end
      prog[prog_len - 1] = {OPC_ACCEPT, 14'h0000};
      // path count with every match taken, bounds the threads any lane sees
      for (int a = 0; a < 256; a++) visits[a] = 0;
      visits[0] = 1;
      total     = 0;
      for (int pc = 0; pc < prog_len; pc++) begin
        total += visits[pc];
        op  = prog[pc][15:14];
        arg = prog[pc][7:0];
        case (op)
          OPC_MATCH: visits[pc + 1] += visits[pc];
          OPC_JMP:   visits[arg] += visits[pc];
          OPC_SPLIT: begin
            visits[pc + 1] += visits[pc];
            visits[arg]    += visits[pc];
          end
          default: ;
        endcase
      end
    end
  endtask

  task automatic reload_and_reset();
    rst_n = 1'b0;
    make_program();                  // cache lines are wiped by the reset
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    compare_value("memory_valid", int'(memory_valid), 0);
    compare_value("output_pc_valid", int'(output_pc_valid), 0);
    compare_value("accepts", int'(accepts), 0);
    compare_value("running", int'(running), 0);
    compare_value("full", int'(full), 0);
    compare_value("elaborating_chars", int'(elaborating_chars), 0);
  endtask

  // new string and end position, then the new_char pulse
  task automatic load_window();
    int         str_len;
    int         pc;
    int         lane;
    bit         guided;
    logic [1:0] op;
    for (int i = 0; i < LANES; i++) win_char[i] = 8'h61 + 8'($urandom_range(0, 2));
    str_len = $urandom_range(0, LANES);
    guided  = ($urandom_range(0, 1) == 1);
    if (guided) begin
      // follow one random path, its match chars spell the string
      pc   = 0;
      lane = 0;
      op   = prog[0][15:14];
      while (lane < LANES && op != OPC_ACCEPT) begin
        case (op)
          OPC_MATCH: begin
            win_char[lane] = prog[pc][7:0];
            lane++;
            pc++;
          end
          OPC_JMP: pc = int'(prog[pc][7:0]);
          default: pc = ($urandom_range(0, 1) == 1) ? int'(prog[pc][7:0]) : pc + 1;  // split
        endcase
        op = prog[pc][15:14];
      end
      str_len = lane;  // string ends where the path stops
    end
    for (int i = 0; i < LANES; i++) end_flag[i] = (i >= str_len);  // set at and after the end
    @(posedge clk);
    #1;
    for (int i = 0; i < LANES; i++) cur_window[i*CW +: CW] = win_char[i];
    cur_window_end_of_s = end_flag;
    new_char            = 1'b1;
    @(posedge clk);
    #1;
    new_char = 1'b0;
  endtask

  // set based nfa over the window, entries are lane*256 + pc
  task automatic run_model();
    int         work[$];
    int         item;
    int         lane;
    int         pc;
    logic [1:0] op;
    logic [7:0] arg;
    exp_accept = 1'b0;
    exp_out.delete();
    work.push_back(0);
    while (work.size() > 0) begin
      item = work.pop_front();
      lane = item / 256;
      pc   = item % 256;
      op   = prog[pc][15:14];
      arg  = prog[pc][7:0];
      case (op)
        OPC_MATCH: begin
          if (!end_flag[lane] && win_char[lane] == arg) begin
            if (lane == LANES - 1) exp_out.push_back(((pc + 1) % 256) << `VE_CC_ID_BITS);
            else work.push_back((lane + 1) * 256 + pc + 1);
          end
        end
        OPC_JMP: work.push_back(lane * 256 + int'(arg));
        OPC_SPLIT: begin
          work.push_back(lane * 256 + pc + 1);  // both halves stay in the lane
          work.push_back(lane * 256 + int'(arg));
        end
        default: if (end_flag[lane]) exp_accept = 1'b1;
      endcase
    end
  endtask

  task automatic run_trial();
    int n;
    load_window();
    run_model();
    got_out.delete();
    input_pc_valid     = 1'b1;
    input_pc_and_cc_id = '0;  // pc 0 in lane 0
    @(negedge clk);
    while (!input_pc_ready) @(negedge clk);
    @(posedge clk);
    #1;
    input_pc_valid = 1'b0;
    @(negedge clk);
    while (running) @(negedge clk);
    compare_value("accepts", int'(accepts), int'(exp_accept));
    compare_value("elaborating_chars", int'(elaborating_chars), 0);
    compare_value("full", int'(full), 0);
    got_out.sort();
    exp_out.sort();
    compare_value("output_pc_and_cc_id count", got_out.size(), exp_out.size());
    n = (got_out.size() < exp_out.size()) ? got_out.size() : exp_out.size();
    for (int i = 0; i < n; i++) compare_value("output_pc_and_cc_id", got_out[i], exp_out[i]);
  endtask

  // memory: ready for one cycle, broadcast 1 to 4 cycles later
  initial begin : memory_model
    int                            gap;
    logic [`VE_MEM_ADDR_WIDTH-1:0] addr;
    forever begin
      @(posedge clk);
      #1;
      if (rst_n && memory_valid) begin
        addr         = memory_addr;
        memory_ready = 1'b1;
        @(posedge clk);  // request taken here
        #1;
        memory_ready = 1'b0;
        gap          = $urandom_range(1, 4);
        repeat (gap) @(posedge clk);
        #1;
        memory_broadcast_valid = 1'b1;
        memory_broadcast_addr  = addr;
        memory_data            = prog[addr];
        @(posedge clk);
        #1;
        memory_broadcast_valid = 1'b0;
      end
    end
  end

  initial begin : output_sink
    forever begin
      @(posedge clk);
      #1;
      if (stall_mode) output_pc_ready = ($urandom_range(0, 2) != 0);
      else output_pc_ready = 1'b1;
    end
  end

  // handshake monitor, everything is settled at the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (hold_out) begin
        check_count++;
        assert (output_pc_valid && output_pc_and_cc_id == last_out) else begin
          error_count++;
          $display("[ERROR] output_pc_and_cc_id: got %h valid %h expected %h held",
                   output_pc_and_cc_id, output_pc_valid, last_out);
        end
      end
      if (hold_mem) begin
        check_count++;
        assert (memory_valid && memory_addr == last_mem_addr) else begin
          error_count++;
          $display("[ERROR] memory_addr: got %h valid %h expected %h held",
                   memory_addr, memory_valid, last_mem_addr);
        end
      end
      if (memory_valid) begin
        check_count++;
        assert (int'(memory_addr) < prog_len) else begin
          error_count++;
          $display("[ERROR] memory_addr: got %h outside a program of %h words",
                   memory_addr, prog_len);
        end
      end
      // every lane is enabled, so busy lanes and running go together
      check_count++;
      assert (running == (|elaborating_chars)) else begin
        error_count++;
        $display("[ERROR] elaborating_chars: got %h while running is %h",
                 elaborating_chars, running);
      end
      if (output_pc_valid && output_pc_ready) got_out.push_back(int'(output_pc_and_cc_id));
      hold_out      = output_pc_valid && !output_pc_ready;
      last_out      = output_pc_and_cc_id;
      hold_mem      = memory_valid && !memory_ready;
      last_mem_addr = memory_addr;
    end else begin
      hold_out = 1'b0;
      hold_mem = 1'b0;
    end
  end

  initial begin : watchdog
    #(N_TRIALS * 2000 * CLK_PERIOD);
    $display("timeout: engine still busy after %0d cycles", N_TRIALS * 2000);
    $display("checks: %0d, errors: %0d", check_count, error_count);
    $display("Finished with errors");
    $finish;
  end

  initial begin : main
    bit fresh;
    void'($urandom(30));
    rst_n                  = 1'b0;
    new_char               = 1'b0;
    cur_window             = '0;
    cur_window_enable      = '1;  // all four lanes run
    cur_window_end_of_s    = '0;
    input_pc_valid         = 1'b0;
    input_pc_and_cc_id     = '0;
    output_pc_ready        = 1'b1;
    memory_ready           = 1'b0;
    memory_broadcast_valid = 1'b0;
    memory_broadcast_addr  = '0;
    memory_data            = '0;
    stall_mode             = 1'b0;
    reload_and_reset();
    for (int t = 0; t < N_TRIALS; t++) begin
      fresh = (t > 0) && ($urandom_range(0, 2) == 0);  // mostly reuse the cached program
      if (fresh) reload_and_reset();
      stall_mode = ($urandom_range(0, 1) == 1);
      run_trial();
    end
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+.
ve_pkg.sv
ve_if.sv
pc_fifo.sv
pc_arbiter_2rr.sv
mem_arbiter_rr.sv
icache_dm.sv
regex_cpu.sv
vectorial_engine.sv
tb_vectorial_engine.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      = tb_vectorial_engine
FILELIST = vlog.f
LOG      = sim.log
PASS_MSG = Finished with no errors

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
